// File: verilog/cpu_bus_pkg.sv
package cpu_bus_pkg;

  // bus widths
  // every port in the subsystem uses these
  localparam int addr_w = 32;
  localparam int data_w = 32;

  // one write strobe per byte lane
  localparam int strb_w = data_w / 8;

  // region boundary
  // soc memory at or above, debug (jtag) memory below
  localparam logic [addr_w-1:0] soc_base = 32'h0200_0000;

  // read arbiter grant states
  // idle samples requests, busy states hold one master until its r handshake
  typedef enum logic [1:0] {
    idle,
    ifu_busy,
    lsu_busy
  } arb_state_t;

  // axi okay response code
  // every transfer completes okay, so the bus carries no resp wires
  // and bvalid or rvalid alone means okay
  localparam logic [1:0] resp_okay = 2'b00;

endpackage

// File: verilog/read_arbiter.sv
`timescale 1ns/1ps

module read_arbiter (
  input  logic                           clock,
  input  logic                           arst_n,
  // instruction fetch read master
  input  logic                           ifu_arvalid,
  output logic                           ifu_arready,
  input  logic [cpu_bus_pkg::addr_w-1:0] ifu_araddr,
  output logic                           ifu_rvalid,
  input  logic                           ifu_rready,
  output logic [cpu_bus_pkg::data_w-1:0] ifu_rdata,
  // load/store read master
  input  logic                           lsu_arvalid,
  output logic                           lsu_arready,
  input  logic [cpu_bus_pkg::addr_w-1:0] lsu_araddr,
  output logic                           lsu_rvalid,
  input  logic                           lsu_rready,
  output logic [cpu_bus_pkg::data_w-1:0] lsu_rdata,
  // merged read port toward the splitter
  output logic                           m_arvalid,
  input  logic                           m_arready,
  output logic [cpu_bus_pkg::addr_w-1:0] m_araddr,
  input  logic                           m_rvalid,
  output logic                           m_rready,
  input  logic [cpu_bus_pkg::data_w-1:0] m_rdata
);
  import cpu_bus_pkg::*;

  arb_state_t state_q;
  arb_state_t state_d;
  // r handshake on the merged port ends a grant
  logic       r_fire;

  assign r_fire = m_rvalid && m_rready;

  // next grant
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      idle: begin
        // lsu wins a tie, ifu only when lsu is quiet
        if (lsu_arvalid) begin
          state_d = lsu_busy;
        end else if (ifu_arvalid) begin
          state_d = ifu_busy;
        end
      end
      ifu_busy, lsu_busy: begin
        // hold until the granted master takes its data
        if (r_fire) begin
          state_d = idle;
        end
      end
      default: begin
        state_d = idle;
      end
    endcase
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= idle;
    end else begin
      state_q <= state_d;
    end
  end

  // steering
  // granted master sees the merged port, the other one sees zeros
  always_comb begin
    m_arvalid   = 1'b0;
    m_araddr    = lsu_araddr;
    m_rready    = 1'b0;
    ifu_arready = 1'b0;
    ifu_rvalid  = 1'b0;
    lsu_arready = 1'b0;
    lsu_rvalid  = 1'b0;
    unique case (state_q)
      ifu_busy: begin
        m_arvalid   = ifu_arvalid;
        m_araddr    = ifu_araddr;
        m_rready    = ifu_rready;
        ifu_arready = m_arready;
        ifu_rvalid  = m_rvalid;
      end
      lsu_busy: begin
        m_arvalid   = lsu_arvalid;
        m_rready    = lsu_rready;
        lsu_arready = m_arready;
        lsu_rvalid  = m_rvalid;
      end
      default: begin
        // idle, nothing forwarded
        m_arvalid = 1'b0;
      end
    endcase
  end

  // read data is shared, rvalid qualifies it per master
  assign ifu_rdata = m_rdata;
  assign lsu_rdata = m_rdata;

  // merged rvalid reaches exactly one master
  a_one_rvalid: assert property (@(posedge clock) disable iff (!arst_n)
    m_rvalid |-> (ifu_rvalid != lsu_rvalid));

  // a stalled response keeps its owner
  a_grant_held: assert property (@(posedge clock) disable iff (!arst_n)
    (m_rvalid && !m_rready) |=> $stable(state_q));

endmodule

// File: verilog/region_splitter.sv
`timescale 1ns/1ps

module region_splitter #(
  parameter logic [cpu_bus_pkg::addr_w-1:0] split_base = cpu_bus_pkg::soc_base
) (
  input  logic                           clock,
  input  logic                           arst_n,
  // merged read port from the arbiter
  input  logic                           m_arvalid,
  output logic                           m_arready,
  input  logic [cpu_bus_pkg::addr_w-1:0] m_araddr,
  output logic                           m_rvalid,
  input  logic                           m_rready,
  output logic [cpu_bus_pkg::data_w-1:0] m_rdata,
  // lsu write port
  input  logic                           lsu_awvalid,
  output logic                           lsu_awready,
  input  logic [cpu_bus_pkg::addr_w-1:0] lsu_awaddr,
  input  logic                           lsu_wvalid,
  output logic                           lsu_wready,
  input  logic [cpu_bus_pkg::data_w-1:0] lsu_wdata,
  input  logic [cpu_bus_pkg::strb_w-1:0] lsu_wstrb,
  output logic                           lsu_bvalid,
  input  logic                           lsu_bready,
  // soc memory target
  output logic                           soc_arvalid,
  input  logic                           soc_arready,
  output logic [cpu_bus_pkg::addr_w-1:0] soc_araddr,
  input  logic                           soc_rvalid,
  output logic                           soc_rready,
  input  logic [cpu_bus_pkg::data_w-1:0] soc_rdata,
  output logic                           soc_awvalid,
  input  logic                           soc_awready,
  output logic [cpu_bus_pkg::addr_w-1:0] soc_awaddr,
  output logic                           soc_wvalid,
  input  logic                           soc_wready,
  output logic [cpu_bus_pkg::data_w-1:0] soc_wdata,
  output logic [cpu_bus_pkg::strb_w-1:0] soc_wstrb,
  input  logic                           soc_bvalid,
  output logic                           soc_bready,
  // debug memory target
  output logic                           dbg_arvalid,
  input  logic                           dbg_arready,
  output logic [cpu_bus_pkg::addr_w-1:0] dbg_araddr,
  input  logic                           dbg_rvalid,
  output logic                           dbg_rready,
  input  logic [cpu_bus_pkg::data_w-1:0] dbg_rdata,
  output logic                           dbg_awvalid,
  input  logic                           dbg_awready,
  output logic [cpu_bus_pkg::addr_w-1:0] dbg_awaddr,
  output logic                           dbg_wvalid,
  input  logic                           dbg_wready,
  output logic [cpu_bus_pkg::data_w-1:0] dbg_wdata,
  output logic [cpu_bus_pkg::strb_w-1:0] dbg_wstrb,
  input  logic                           dbg_bvalid,
  output logic                           dbg_bready
);

  // address decode of the incoming requests
  logic ar_soc;
  logic aw_soc;
  // latched routes, held until the response completes
  logic rd_held_q;
  logic rd_soc_q;
  logic wr_held_q;
  logic wr_soc_q;
  logic ar_fire;
  logic r_fire;
  logic aw_fire;
  logic b_fire;

  assign ar_soc = m_araddr >= split_base;
  assign aw_soc = lsu_awaddr >= split_base;

  // ar channel
  // closed while a read route is held, one read in flight
  assign soc_arvalid = m_arvalid && ar_soc && !rd_held_q;
  assign dbg_arvalid = m_arvalid && !ar_soc && !rd_held_q;
  assign soc_araddr  = m_araddr;
  assign dbg_araddr  = m_araddr;
  assign m_arready   = !rd_held_q && (ar_soc ? soc_arready : dbg_arready);

  // r channel follows the latched route, not the live address
  assign m_rvalid   = rd_held_q && (rd_soc_q ? soc_rvalid : dbg_rvalid);
  assign m_rdata    = rd_soc_q ? soc_rdata : dbg_rdata;
  assign soc_rready = rd_held_q && rd_soc_q && m_rready;
  assign dbg_rready = rd_held_q && !rd_soc_q && m_rready;

  // aw and w channels
  // both routed by awaddr, targets accept them in the same cycle
  assign soc_awvalid = lsu_awvalid && aw_soc && !wr_held_q;
  assign dbg_awvalid = lsu_awvalid && !aw_soc && !wr_held_q;
  assign soc_awaddr  = lsu_awaddr;
  assign dbg_awaddr  = lsu_awaddr;
  assign soc_wvalid  = lsu_wvalid && aw_soc && !wr_held_q;
  assign dbg_wvalid  = lsu_wvalid && !aw_soc && !wr_held_q;
  assign soc_wdata   = lsu_wdata;
  assign dbg_wdata   = lsu_wdata;
  assign soc_wstrb   = lsu_wstrb;
  assign dbg_wstrb   = lsu_wstrb;
  assign lsu_awready = !wr_held_q && (aw_soc ? soc_awready : dbg_awready);
  assign lsu_wready  = !wr_held_q && (aw_soc ? soc_wready : dbg_wready);

  // b channel from the latched write route
  assign lsu_bvalid = wr_held_q && (wr_soc_q ? soc_bvalid : dbg_bvalid);
  assign soc_bready = wr_held_q && wr_soc_q && lsu_bready;
  assign dbg_bready = wr_held_q && !wr_soc_q && lsu_bready;

  assign ar_fire = m_arvalid && m_arready;
  assign r_fire  = m_rvalid && m_rready;
  assign aw_fire = lsu_awvalid && lsu_awready;
  assign b_fire  = lsu_bvalid && lsu_bready;

  // read route
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      rd_held_q <= 1'b0;
      rd_soc_q  <= 1'b0;
    end else if (ar_fire) begin
      rd_held_q <= 1'b1;
      rd_soc_q  <= ar_soc;
    end else if (r_fire) begin
      rd_held_q <= 1'b0;
    end
  end

  // write route
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      wr_held_q <= 1'b0;
      wr_soc_q  <= 1'b0;
    end else if (aw_fire) begin
      wr_held_q <= 1'b1;
      wr_soc_q  <= aw_soc;
    end else if (b_fire) begin
      wr_held_q <= 1'b0;
    end
  end

  // a target only answers while a route to it is held
  a_soc_r_routed: assert property (@(posedge clock) disable iff (!arst_n)
    soc_rvalid |-> (rd_held_q && rd_soc_q));
  a_dbg_r_routed: assert property (@(posedge clock) disable iff (!arst_n)
    dbg_rvalid |-> (rd_held_q && !rd_soc_q));
  a_soc_b_routed: assert property (@(posedge clock) disable iff (!arst_n)
    soc_bvalid |-> (wr_held_q && wr_soc_q));
  a_dbg_b_routed: assert property (@(posedge clock) disable iff (!arst_n)
    dbg_bvalid |-> (wr_held_q && !wr_soc_q));

endmodule

// File: verilog/onchip_mem_slave.sv
`timescale 1ns/1ps

module onchip_mem_slave #(
  parameter int mem_words = 256
) (
  input  logic                           clock,
  input  logic                           arst_n,
  // read address and data
  input  logic                           arvalid,
  output logic                           arready,
  input  logic [cpu_bus_pkg::addr_w-1:0] araddr,
  output logic                           rvalid,
  input  logic                           rready,
  output logic [cpu_bus_pkg::data_w-1:0] rdata,
  // write address, data and response
  input  logic                           awvalid,
  output logic                           awready,
  input  logic [cpu_bus_pkg::addr_w-1:0] awaddr,
  input  logic                           wvalid,
  output logic                           wready,
  input  logic [cpu_bus_pkg::data_w-1:0] wdata,
  input  logic [cpu_bus_pkg::strb_w-1:0] wstrb,
  output logic                           bvalid,
  input  logic                           bready
);
  import cpu_bus_pkg::*;

  // word index width
  localparam int idx_w = (mem_words > 1) ? $clog2(mem_words) : 1;

  logic [data_w-1:0] mem [mem_words];
  logic [idx_w-1:0]  rd_idx;
  logic [idx_w-1:0]  wr_idx;
  logic              ar_fire;
  logic              wr_go;

  // word address wraps at mem_words
  assign rd_idx = idx_w'(araddr[addr_w-1:2] % mem_words);
  assign wr_idx = idx_w'(awaddr[addr_w-1:2] % mem_words);

  // one read pending at most
  assign arready = !rvalid;
  assign ar_fire = arvalid && arready;

  // aw and w taken together, only with no b waiting
  assign wr_go   = awvalid && wvalid && !bvalid;
  assign awready = wr_go;
  assign wready  = wr_go;

  // read data register, held while rvalid waits for rready
  always_ff @(posedge clock) begin
    if (ar_fire) begin
      rdata <= mem[rd_idx];
    end
  end

  // byte lane merge
  always_ff @(posedge clock) begin
    if (wr_go) begin
      for (int i = 0; i < strb_w; i++) begin
        if (wstrb[i]) begin
          mem[wr_idx][8*i +: 8] <= wdata[8*i +: 8];
        end
      end
    end
  end

  // response valids
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      rvalid <= 1'b0;
      bvalid <= 1'b0;
    end else begin
      if (ar_fire) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
      if (wr_go) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  // address and data accepted together and b follows on the next edge
  a_aw_with_w: assert property (@(posedge clock) disable iff (!arst_n)
    awready |-> wready ##1 bvalid);

endmodule

// File: verilog/mem_subsystem_top.sv
`timescale 1ns/1ps

module mem_subsystem_top #(
  parameter int                             mem_words_soc = 256,
  parameter int                             mem_words_dbg = 256,
  parameter logic [cpu_bus_pkg::addr_w-1:0] split_base    = cpu_bus_pkg::soc_base
) (
  input  logic                           clock,
  input  logic                           arst_n,
  // ifu read
  input  logic                           ifu_arvalid,
  output logic                           ifu_arready,
  input  logic [cpu_bus_pkg::addr_w-1:0] ifu_araddr,
  output logic                           ifu_rvalid,
  input  logic                           ifu_rready,
  output logic [cpu_bus_pkg::data_w-1:0] ifu_rdata,
  // lsu read
  input  logic                           lsu_arvalid,
  output logic                           lsu_arready,
  input  logic [cpu_bus_pkg::addr_w-1:0] lsu_araddr,
  output logic                           lsu_rvalid,
  input  logic                           lsu_rready,
  output logic [cpu_bus_pkg::data_w-1:0] lsu_rdata,
  // lsu write
  input  logic                           lsu_awvalid,
  output logic                           lsu_awready,
  input  logic [cpu_bus_pkg::addr_w-1:0] lsu_awaddr,
  input  logic                           lsu_wvalid,
  output logic                           lsu_wready,
  input  logic [cpu_bus_pkg::data_w-1:0] lsu_wdata,
  input  logic [cpu_bus_pkg::strb_w-1:0] lsu_wstrb,
  output logic                           lsu_bvalid,
  input  logic                           lsu_bready
);
  import cpu_bus_pkg::*;

  // merged read port, arbiter to splitter
  logic              m_arvalid;
  logic              m_arready;
  logic [addr_w-1:0] m_araddr;
  logic              m_rvalid;
  logic              m_rready;
  logic [data_w-1:0] m_rdata;

  // soc memory link
  logic              soc_arvalid;
  logic              soc_arready;
  logic [addr_w-1:0] soc_araddr;
  logic              soc_rvalid;
  logic              soc_rready;
  logic [data_w-1:0] soc_rdata;
  logic              soc_awvalid;
  logic              soc_awready;
  logic [addr_w-1:0] soc_awaddr;
  logic              soc_wvalid;
  logic              soc_wready;
  logic [data_w-1:0] soc_wdata;
  logic [strb_w-1:0] soc_wstrb;
  logic              soc_bvalid;
  logic              soc_bready;

  // debug memory link
  logic              dbg_arvalid;
  logic              dbg_arready;
  logic [addr_w-1:0] dbg_araddr;
  logic              dbg_rvalid;
  logic              dbg_rready;
  logic [data_w-1:0] dbg_rdata;
  logic              dbg_awvalid;
  logic              dbg_awready;
  logic [addr_w-1:0] dbg_awaddr;
  logic              dbg_wvalid;
  logic              dbg_wready;
  logic [data_w-1:0] dbg_wdata;
  logic [strb_w-1:0] dbg_wstrb;
  logic              dbg_bvalid;
  logic              dbg_bready;

  // port names line up with the wires above
  read_arbiter u_arb (.*);

  region_splitter #(
    .split_base(split_base)
  ) u_split (.*);

  // at or above split_base
  onchip_mem_slave #(
    .mem_words(mem_words_soc)
  ) u_soc_mem (
    .clock  (clock),
    .arst_n (arst_n),
    .arvalid(soc_arvalid),
    .arready(soc_arready),
    .araddr (soc_araddr),
    .rvalid (soc_rvalid),
    .rready (soc_rready),
    .rdata  (soc_rdata),
    .awvalid(soc_awvalid),
    .awready(soc_awready),
    .awaddr (soc_awaddr),
    .wvalid (soc_wvalid),
    .wready (soc_wready),
    .wdata  (soc_wdata),
    .wstrb  (soc_wstrb),
    .bvalid (soc_bvalid),
    .bready (soc_bready)
  );

  // below split_base, jtag side
  onchip_mem_slave #(
    .mem_words(mem_words_dbg)
  ) u_dbg_mem (
    .clock  (clock),
    .arst_n (arst_n),
    .arvalid(dbg_arvalid),
    .arready(dbg_arready),
    .araddr (dbg_araddr),
    .rvalid (dbg_rvalid),
    .rready (dbg_rready),
    .rdata  (dbg_rdata),
    .awvalid(dbg_awvalid),
    .awready(dbg_awready),
    .awaddr (dbg_awaddr),
    .wvalid (dbg_wvalid),
    .wready (dbg_wready),
    .wdata  (dbg_wdata),
    .wstrb  (dbg_wstrb),
    .bvalid (dbg_bvalid),
    .bready (dbg_bready)
  );

endmodule

// File: verification/tb_bus_tasks.svh
`ifndef tb_bus_tasks_svh
`define tb_bus_tasks_svh

// reference memory, byte-merged words keyed by byte address
logic [data_w-1:0] model [logic [addr_w-1:0]];

// expected read data per master, picked up by the data checks
logic [data_w-1:0] exp_ifu = '0;
logic [data_w-1:0] exp_lsu = '0;

// completed transactions
int n_done = 0;

// byte lane merge under the write strobes
function automatic logic [data_w-1:0] merge_bytes(input logic [data_w-1:0] old_word,
                                                  input logic [data_w-1:0] new_word,
                                                  input logic [strb_w-1:0] strb);
  logic [data_w-1:0] res;
  res = old_word;
  for (int i = 0; i < strb_w; i++) begin
    if (strb[i]) begin
      res[8*i +: 8] = new_word[8*i +: 8];
    end
  end
  return res;
endfunction

// single lsu write, bready held low for stall cycles once bvalid is up
task automatic lsu_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
                         input logic [strb_w-1:0] strb, input int stall);
  @(posedge clock);
  lsu_awaddr  <= addr;
  lsu_wdata   <= data;
  lsu_wstrb   <= strb;
  lsu_awvalid <= 1'b1;
  lsu_wvalid  <= 1'b1;
  lsu_bready  <= (stall == 0);
  // aw and w go together, ready seen mid cycle
  do @(negedge clock); while (!(lsu_awready && lsu_wready));
  @(posedge clock);
  lsu_awvalid <= 1'b0;
  lsu_wvalid  <= 1'b0;
  model[addr] = merge_bytes(model.exists(addr) ? model[addr] : 'x, data, strb);
  do @(negedge clock); while (!lsu_bvalid);
  if (stall > 0) begin
    repeat (stall) @(posedge clock);
    lsu_bready <= 1'b1;
    @(negedge clock);
  end
  // b handshake on this edge
  @(posedge clock);
  n_done++;
endtask

// single read by ifu or lsu, rready held low for stall cycles
task automatic bus_read(input logic by_lsu, input logic [addr_w-1:0] addr,
                        input int stall);
  logic [data_w-1:0] want;
  want = model.exists(addr) ? model[addr] : 'x;
  @(posedge clock);
  if (by_lsu) begin
    exp_lsu     <= want;
    lsu_araddr  <= addr;
    lsu_arvalid <= 1'b1;
    lsu_rready  <= (stall == 0);
  end else begin
    exp_ifu     <= want;
    ifu_araddr  <= addr;
    ifu_arvalid <= 1'b1;
    ifu_rready  <= (stall == 0);
  end
  do @(negedge clock); while (!(by_lsu ? lsu_arready : ifu_arready));
  @(posedge clock);
  if (by_lsu) begin
    lsu_arvalid <= 1'b0;
  end else begin
    ifu_arvalid <= 1'b0;
  end
  do @(negedge clock); while (!(by_lsu ? lsu_rvalid : ifu_rvalid));
  if (stall > 0) begin
    repeat (stall) @(posedge clock);
    if (by_lsu) begin
      lsu_rready <= 1'b1;
    end else begin
      ifu_rready <= 1'b1;
    end
    @(negedge clock);
  end
  // r handshake on this edge
  @(posedge clock);
  n_done++;
endtask

`endif

// File: verification/tb_mem_subsystem.sv
`timescale 1ns/1ps

module tb_mem_subsystem;
  import cpu_bus_pkg::*;

  // stimulus sizes
  localparam int n_rand     = 16;
  localparam int n_region   = 4;
  localparam int n_arb      = 4;
  localparam int n_stall    = 8;
  // three per random address, four per region pair, two per race or stall round
  localparam int n_trans    = 3 * n_rand + 4 * n_region + 2 * n_arb + 2 * n_stall;
  localparam int rst_cycles = 16;
  localparam int max_cycles = 40 * n_trans + rst_cycles + 8;

  logic              clock;
  logic              arst_n;
  logic              ifu_arvalid;
  logic              ifu_arready;
  logic [addr_w-1:0] ifu_araddr;
  logic              ifu_rvalid;
  logic              ifu_rready;
  logic [data_w-1:0] ifu_rdata;
  logic              lsu_arvalid;
  logic              lsu_arready;
  logic [addr_w-1:0] lsu_araddr;
  logic              lsu_rvalid;
  logic              lsu_rready;
  logic [data_w-1:0] lsu_rdata;
  logic              lsu_awvalid;
  logic              lsu_awready;
  logic [addr_w-1:0] lsu_awaddr;
  logic              lsu_wvalid;
  logic              lsu_wready;
  logic [data_w-1:0] lsu_wdata;
  logic [strb_w-1:0] lsu_wstrb;
  logic              lsu_bvalid;
  logic              lsu_bready;

  string             test_name = "reset";
  int                errors = 0;
  int                cycles = 0;
  logic              rst_window = 1'b1;
  // high from ar handshake to r handshake
  logic              ifu_pend;
  logic              lsu_pend;
  // read data one edge back, for the stall checks
  logic [data_w-1:0] ifu_rdata_q;
  logic [data_w-1:0] lsu_rdata_q;
  // no read request or response anywhere
  logic              rd_quiet;
  // fully written addresses, reused by later phases
  logic [addr_w-1:0] addrs [$];

  mem_subsystem_top u_dut (.*);

  `include "tb_bus_tasks.svh"

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  assign rd_quiet = !(ifu_arvalid || lsu_arvalid || ifu_rvalid || lsu_rvalid);

  always @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      ifu_pend <= 1'b0;
      lsu_pend <= 1'b0;
    end else begin
      if (ifu_arvalid && ifu_arready) begin
        ifu_pend <= 1'b1;
      end else if (ifu_rvalid && ifu_rready) begin
        ifu_pend <= 1'b0;
      end
      if (lsu_arvalid && lsu_arready) begin
        lsu_pend <= 1'b1;
      end else if (lsu_rvalid && lsu_rready) begin
        lsu_pend <= 1'b0;
      end
    end
  end

  always @(posedge clock) begin
    ifu_rdata_q <= ifu_rdata;
    lsu_rdata_q <= lsu_rdata;
  end

  // quiet bus in and right after reset
  a_reset_quiet: assert property (@(posedge clock)
    rst_window |-> !(ifu_rvalid || lsu_rvalid || lsu_bvalid || ifu_arready || lsu_arready ||
                     lsu_awready || lsu_wready))
    else begin
      errors++;
      $display("%s: a valid or ready output was high in or right after reset", test_name);
    end

  // read data against the model
  a_lsu_data: assert property (@(posedge clock) disable iff (!arst_n)
    (lsu_rvalid && lsu_rready) |-> (lsu_rdata == exp_lsu))
    else begin
      errors++;
      $display("ERROR %s: lsu read expected %h actual %h", test_name,
               $sampled(exp_lsu), $sampled(lsu_rdata));
    end
  a_ifu_data: assert property (@(posedge clock) disable iff (!arst_n)
    (ifu_rvalid && ifu_rready) |-> (ifu_rdata == exp_ifu))
    else begin
      errors++;
      $display("ERROR %s: ifu read expected %h actual %h", test_name,
               $sampled(exp_ifu), $sampled(ifu_rdata));
    end

  // idle bus, rvalid two edges after arvalid is first seen
  a_lsu_latency: assert property (@(posedge clock) disable iff (!arst_n)
    ($past(rd_quiet) && lsu_arvalid) |-> ##2 lsu_rvalid)
    else begin
      errors++;
      $display("%s: lsu rvalid missed the two cycle read latency", test_name);
    end
  a_ifu_latency: assert property (@(posedge clock) disable iff (!arst_n)
    ($past(rd_quiet) && ifu_arvalid && !lsu_arvalid) |-> ##2 ifu_rvalid)
    else begin
      errors++;
      $display("%s: ifu rvalid missed the two cycle read latency", test_name);
    end

  // tie goes to lsu
  a_lsu_first: assert property (@(posedge clock) disable iff (!arst_n)
    ($past(rd_quiet) && ifu_arvalid && lsu_arvalid) |-> ##2 (lsu_rvalid && !ifu_rvalid))
    else begin
      errors++;
      $display("%s: lsu did not win the same cycle request", test_name);
    end

  // stalled responses hold
  a_lsu_r_hold: assert property (@(posedge clock) disable iff (!arst_n)
    (lsu_rvalid && !lsu_rready) |=> (lsu_rvalid && lsu_rdata == lsu_rdata_q))
    else begin
      errors++;
      $display("ERROR %s: lsu stalled read expected %h actual %h (rvalid %b)", test_name,
               $sampled(lsu_rdata_q), $sampled(lsu_rdata), $sampled(lsu_rvalid));
    end
  a_ifu_r_hold: assert property (@(posedge clock) disable iff (!arst_n)
    (ifu_rvalid && !ifu_rready) |=> (ifu_rvalid && ifu_rdata == ifu_rdata_q))
    else begin
      errors++;
      $display("ERROR %s: ifu stalled read expected %h actual %h (rvalid %b)", test_name,
               $sampled(ifu_rdata_q), $sampled(ifu_rdata), $sampled(ifu_rvalid));
    end
  a_b_hold: assert property (@(posedge clock) disable iff (!arst_n)
    (lsu_bvalid && !lsu_bready) |=> lsu_bvalid)
    else begin
      errors++;
      $display("%s: lsu bvalid dropped before bready", test_name);
    end

  // aw and w only accepted together and with no b waiting
  a_aw_w_ready: assert property (@(posedge clock) disable iff (!arst_n)
    (lsu_awready || lsu_wready) |->
      (lsu_awready && lsu_wready && lsu_awvalid && lsu_wvalid && !lsu_bvalid))
    else begin
      errors++;
      $display("%s: lsu awready and wready broke the write accept rule", test_name);
    end

  // b one cycle after the aw and w handshake
  a_b_latency: assert property (@(posedge clock) disable iff (!arst_n)
    (lsu_awvalid && lsu_awready && lsu_wvalid && lsu_wready) |=> lsu_bvalid)
    else begin
      errors++;
      $display("%s: lsu bvalid did not rise one cycle after the write", test_name);
    end

  // one read in flight per master
  a_lsu_one_ar: assert property (@(posedge clock) disable iff (!arst_n)
    lsu_pend |-> !lsu_arready)
    else begin
      errors++;
      $display("%s: lsu saw arready again before its read data", test_name);
    end
  a_ifu_one_ar: assert property (@(posedge clock) disable iff (!arst_n)
    ifu_pend |-> !ifu_arready)
    else begin
      errors++;
      $display("%s: ifu saw arready again before its read data", test_name);
    end

  initial begin
    logic [addr_w-1:0] a0;
    logic [addr_w-1:0] a1;
    logic [data_w-1:0] d0;
    void'($urandom(82903));
    ifu_arvalid <= 1'b0;
    ifu_araddr  <= '0;
    ifu_rready  <= 1'b1;
    lsu_arvalid <= 1'b0;
    lsu_araddr  <= '0;
    lsu_rready  <= 1'b1;
    lsu_awvalid <= 1'b0;
    lsu_awaddr  <= '0;
    lsu_wvalid  <= 1'b0;
    lsu_wdata   <= '0;
    lsu_wstrb   <= '0;
    lsu_bready  <= 1'b1;
    arst_n      <= 1'b0;
    repeat (rst_cycles) @(posedge clock);
    arst_n <= 1'b1;
    repeat (4) @(posedge clock);
    rst_window <= 1'b0;

    // full word, then a partial merge, then a read by either master
    test_name = "write_read";
    for (int i = 0; i < n_rand; i++) begin
      a0 = (($urandom % 2) == 1 ? soc_base : '0) + 32'((i * 16 + $urandom % 16) * 4);
      lsu_write(a0, $urandom, 4'hf, 0);
      lsu_write(a0, $urandom, 4'($urandom), 0);
      bus_read(1'($urandom % 2), a0, 0);
      addrs.push_back(a0);
    end

    // same offset on both sides of the boundary
    test_name = "region";
    for (int i = 0; i < n_region; i++) begin
      a0 = 32'(($urandom % 256) * 4);
      d0 = $urandom;
      lsu_write(a0, d0, 4'hf, 0);
      lsu_write(soc_base + a0, ~d0, 4'hf, 0);
      bus_read(1'b0, a0, 0);
      bus_read(1'b1, soc_base + a0, 0);
    end

    // both masters request on the same edge
    test_name = "arbitration";
    for (int i = 0; i < n_arb; i++) begin
      a0 = addrs[$urandom % addrs.size()];
      a1 = addrs[$urandom % addrs.size()];
      fork
        bus_read(1'b0, a0, 0);
        bus_read(1'b1, a1, 0);
      join
    end

    // random stalls on bready and rready
    test_name = "back_pressure";
    for (int i = 0; i < n_stall; i++) begin
      a0 = addrs[$urandom % addrs.size()];
      lsu_write(a0, $urandom, 4'($urandom), 1 + int'($urandom % 8));
      bus_read(1'($urandom % 2), a0, 1 + int'($urandom % 8));
    end

    repeat (4) @(posedge clock);
    $display("transactions %0d of %0d, errors %0d", n_done, n_trans, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // run limit
  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles == max_cycles) begin
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $display("Checks failed");
      $finish;
    end
  end

endmodule

// File: sources.f
+incdir+verification
verilog/cpu_bus_pkg.sv
verilog/read_arbiter.sv
verilog/region_splitter.sv
verilog/onchip_mem_slave.sv
verilog/mem_subsystem_top.sv
verification/tb_mem_subsystem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the memory subsystem testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f \
  --top-module tb_mem_subsystem -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out="$(./obj_dir/tb_sim)"
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "All checks passed"; then
  exit 0
fi
exit 1
